/* cache_macros.svh */
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// --------------------------------------------------
// Address and data widths
// --------------------------------------------------

`define CACHE_ADDR_W          32  // Byte address
`define CACHE_DATA_W          32  // One word

// --------------------------------------------------
// Cache geometry
// --------------------------------------------------

`define CACHE_NUM_LINES       16  // Direct mapped
`define CACHE_WORDS_PER_LINE  4
`define CACHE_INDEX_W         4   // log2 of line count
`define CACHE_WORD_SEL_W      2   // log2 of words per line
`define CACHE_BYTE_OFF_W      2   // Word aligned accesses only

// Whatever is left of the address after index, word and byte bits
`define CACHE_TAG_W           24

`endif

/* cache_pkg.sv */
package cache_pkg;

  `include "cache_macros.svh"

  // --------------------------------------------------
  // Address decoding
  // --------------------------------------------------

  typedef struct packed {
    logic [`CACHE_TAG_W-1:0]      tag;
    logic [`CACHE_INDEX_W-1:0]    index;
    logic [`CACHE_WORD_SEL_W-1:0] word_sel;
    logic [`CACHE_BYTE_OFF_W-1:0] byte_off;  // Ignored by the cache
  } cache_addr_fields_t;

  // Flat for memory messages, split for lookup
  typedef union packed {
    logic [`CACHE_ADDR_W-1:0] flat;
    cache_addr_fields_t       fields;
  } cache_addr_u;

  // --------------------------------------------------
  // Messages, same format on both ports
  // --------------------------------------------------

  typedef struct packed {
    logic                     op;    // 0 read, 1 write
    logic [`CACHE_ADDR_W-1:0] addr;
    logic [`CACHE_DATA_W-1:0] data;
  } mem_req_t;

  typedef struct packed {
    logic                     op;    // Echoes request type
    logic [`CACHE_DATA_W-1:0] data;  // Undefined for writes
  } mem_resp_t;

  // --------------------------------------------------
  // Control
  // --------------------------------------------------

  typedef enum logic [2:0] {
    STATE_IDLE      = 3'd0,
    STATE_TAG_CHECK = 3'd1,
    STATE_SPILL     = 3'd2,
    STATE_REFILL    = 3'd3,
    STATE_RESP      = 3'd4
  } ctrl_state_e;

  typedef struct packed {
    logic req_en;          // Capture processor request
    logic tag_refill_wen;  // New tag, valid, clean
    logic tag_dirty_wen;   // Mark line dirty on write hit
    logic darray_wen;
    logic wdata_sel;       // 0 processor data, 1 refill data
    logic cnt_clear;
    logic cnt_step;
    logic cnt_word_sel;    // Array word from counter, not request
    logic addr_sel;        // 0 victim address, 1 requested line
  } dpath_ctrl_t;

  typedef struct packed {
    logic hit;
    logic victim_dirty;
    logic last_word;       // Counter sits on the final word
    logic req_type;        // Registered request op
  } dpath_status_t;

endpackage

/* cache_tag_array.sv */
`timescale 1ns/1ps

`include "cache_macros.svh"

module cache_tag_array
  import cache_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic [`CACHE_INDEX_W-1:0] index,
  input  logic [`CACHE_TAG_W-1:0]   req_tag,
  input  dpath_ctrl_t              dctl,
  output logic                     hit,
  output logic                     victim_dirty,
  output logic [`CACHE_TAG_W-1:0]   victim_tag
);

  logic [`CACHE_TAG_W-1:0]    tags [`CACHE_NUM_LINES];
  logic [`CACHE_NUM_LINES-1:0] valid;
  logic [`CACHE_NUM_LINES-1:0] dirty;

  // --------------------------------------------------
  // Lookup, combinational on registered index
  // --------------------------------------------------

  assign victim_tag   = tags[index];
  assign hit          = valid[index] && (tags[index] == req_tag);
  assign victim_dirty = valid[index] && dirty[index];  // Invalid line never spills

  // --------------------------------------------------
  // State bits
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
      dirty <= '0;
    end else if (dctl.tag_refill_wen) begin
      valid[index] <= 1'b1;
      dirty[index] <= 1'b0;  // Fresh line matches memory
    end else if (dctl.tag_dirty_wen) begin
      dirty[index] <= 1'b1;
    end
  end

  // Tag storage
  always_ff @(posedge clk) begin
    if (dctl.tag_refill_wen) begin
      tags[index] <= req_tag;
    end
  end

endmodule

/* cache_dpath.sv */
`timescale 1ns/1ps

`include "cache_macros.svh"

module cache_dpath
  import cache_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  mem_req_t                  memreq,
  input  dpath_ctrl_t               dctl,
  input  logic [`CACHE_TAG_W-1:0]    victim_tag,
  input  mem_resp_t                 cache_resp,
  output logic [`CACHE_INDEX_W-1:0]  index,
  output logic [`CACHE_TAG_W-1:0]    req_tag,
  output dpath_status_t             status,
  output mem_req_t                  cache_req,
  output mem_resp_t                 memresp
);

  localparam int ARRAY_WORDS = `CACHE_NUM_LINES * `CACHE_WORDS_PER_LINE;

  logic                                       req_op;
  cache_addr_u                                req_addr;
  logic [`CACHE_DATA_W-1:0]                    req_data;
  logic [`CACHE_WORD_SEL_W-1:0]                word_cnt;
  logic [`CACHE_WORD_SEL_W-1:0]                word_sel;
  logic [`CACHE_INDEX_W+`CACHE_WORD_SEL_W-1:0]  array_addr;
  logic [`CACHE_DATA_W-1:0]                    data_array [ARRAY_WORDS];
  logic [`CACHE_DATA_W-1:0]                    rd_data;
  logic [`CACHE_DATA_W-1:0]                    wr_data;
  cache_addr_u                                mem_addr;

  // --------------------------------------------------
  // Request registers
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (dctl.req_en) begin
      req_op        <= memreq.op;
      req_addr.flat <= memreq.addr;
      req_data      <= memreq.data;
    end
  end

  assign index   = req_addr.fields.index;
  assign req_tag = req_addr.fields.tag;

  // --------------------------------------------------
  // Line word counter
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      word_cnt <= '0;
    end else if (dctl.cnt_clear) begin
      word_cnt <= '0;
    end else if (dctl.cnt_step) begin
      word_cnt <= word_cnt + 1'b1;  // Wraps after word 3
    end
  end

  // --------------------------------------------------
  // Data array
  // --------------------------------------------------

  // Counter drives the word during spill and refill
  assign word_sel   = dctl.cnt_word_sel ? word_cnt : req_addr.fields.word_sel;
  assign array_addr = {index, word_sel};
  assign rd_data    = data_array[array_addr];
  assign wr_data    = dctl.wdata_sel ? cache_resp.data : req_data;

  always_ff @(posedge clk) begin
    if (dctl.darray_wen) begin
      data_array[array_addr] <= wr_data;
    end
  end

  // --------------------------------------------------
  // Memory request
  // --------------------------------------------------

  always_comb begin
    mem_addr.fields.tag      = dctl.addr_sel ? req_addr.fields.tag : victim_tag;
    mem_addr.fields.index    = index;
    mem_addr.fields.word_sel = word_cnt;
    mem_addr.fields.byte_off = '0;
    cache_req.op   = ~dctl.addr_sel;  // Spill writes, refill reads
    cache_req.addr = mem_addr.flat;
    cache_req.data = rd_data;         // Don't care on refill reads
  end

  // Processor response, array word of the request
  assign memresp.op   = req_op;
  assign memresp.data = rd_data;

  // --------------------------------------------------
  // Status back to control
  // --------------------------------------------------

  assign status.hit          = 1'b0;  // Tag array reports lookup on its own ports
  assign status.victim_dirty = 1'b0;
  assign status.last_word    = (word_cnt == {`CACHE_WORD_SEL_W{1'b1}});  // Word 3
  assign status.req_type     = req_op;

endmodule

/* cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl
  import cache_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  logic          memreq_val,
  input  logic          memresp_rdy,
  input  logic          cache_req_rdy,
  input  logic          cache_resp_val,
  input  logic          hit,
  input  logic          victim_dirty,
  input  dpath_status_t status,
  output logic          memreq_rdy,
  output logic          memresp_val,
  output logic          cache_req_val,
  output logic          cache_resp_rdy,
  output dpath_ctrl_t   dctl
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        pend_q;            // Memory word request outstanding
  logic        req_fire;
  logic        resp_fire;
  logic        spill_req_sent;
  logic        spill_word_done;
  logic        refill_req_sent;
  logic        refill_resp_recv;

  // --------------------------------------------------
  // Memory handshake strobes
  // --------------------------------------------------

  assign req_fire  = cache_req_val && cache_req_rdy;
  assign resp_fire = cache_resp_val && cache_resp_rdy;

  assign spill_req_sent   = (state_q == STATE_SPILL) && req_fire;
  assign spill_word_done  = (state_q == STATE_SPILL) && resp_fire;   // Write acked
  assign refill_req_sent  = (state_q == STATE_REFILL) && req_fire;
  assign refill_resp_recv = (state_q == STATE_REFILL) && resp_fire;  // Data in hand

  // One word in flight at a time
  always_ff @(posedge clk) begin
    if (reset) begin
      pend_q <= 1'b0;
    end else if (spill_req_sent || refill_req_sent) begin
      pend_q <= 1'b1;
    end else if (spill_word_done || refill_resp_recv) begin
      pend_q <= 1'b0;
    end
  end

  // --------------------------------------------------
  // State register and transitions
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= STATE_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;  // Hold by default
    case (state_q)
      STATE_IDLE: begin
        if (memreq_val) state_d = STATE_TAG_CHECK;
      end
      STATE_TAG_CHECK: begin
        if (hit)               state_d = STATE_RESP;
        else if (victim_dirty) state_d = STATE_SPILL;   // Write back first
        else                   state_d = STATE_REFILL;  // Victim clean or invalid
      end
      STATE_SPILL: begin
        if (spill_word_done && status.last_word) state_d = STATE_REFILL;
      end
      STATE_REFILL: begin
        // Back to lookup, which now hits
        if (refill_resp_recv && status.last_word) state_d = STATE_TAG_CHECK;
      end
      STATE_RESP: begin
        if (memresp_rdy) state_d = STATE_IDLE;
      end
      default: state_d = STATE_IDLE;
    endcase
  end

  // --------------------------------------------------
  // State outputs
  // --------------------------------------------------

  always_comb begin
    memreq_rdy     = 1'b0;
    memresp_val    = 1'b0;
    cache_req_val  = 1'b0;
    cache_resp_rdy = 1'b0;
    dctl           = '0;
    case (state_q)
      STATE_IDLE: begin
        memreq_rdy  = 1'b1;
        dctl.req_en = memreq_val;  // Capture on acceptance
      end
      STATE_TAG_CHECK: begin
        if (hit) begin
          if (status.req_type) begin  // Write hit
            dctl.tag_dirty_wen = 1'b1;
            dctl.darray_wen    = 1'b1;
          end
        end else begin
          dctl.cnt_clear = 1'b1;      // Start of spill or refill
        end
      end
      STATE_SPILL: begin
        cache_req_val     = !pend_q;
        cache_resp_rdy    = pend_q;
        dctl.cnt_word_sel = 1'b1;
        dctl.cnt_step     = spill_word_done;
        dctl.cnt_clear    = spill_word_done && status.last_word;  // Refill restarts at 0
      end
      STATE_REFILL: begin
        cache_req_val       = !pend_q;
        cache_resp_rdy      = pend_q;
        dctl.cnt_word_sel   = 1'b1;
        dctl.addr_sel       = 1'b1;
        dctl.wdata_sel      = 1'b1;
        dctl.darray_wen     = refill_resp_recv;
        dctl.cnt_step       = refill_resp_recv;
        dctl.tag_refill_wen = refill_resp_recv && status.last_word;
      end
      STATE_RESP: begin
        memresp_val = 1'b1;  // Held until processor takes it
      end
      default: begin
      end
    endcase
  end

endmodule

/* cache_top.sv */
`timescale 1ns/1ps

`include "cache_macros.svh"

module cache_top
  import cache_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  // Processor side
  input  logic      memreq_val,
  input  mem_req_t  memreq,
  output logic      memreq_rdy,
  output logic      memresp_val,
  output mem_resp_t memresp,
  input  logic      memresp_rdy,
  // Memory side
  output logic      cache_req_val,
  output mem_req_t  cache_req,
  input  logic      cache_req_rdy,
  input  logic      cache_resp_val,
  input  mem_resp_t cache_resp,
  output logic      cache_resp_rdy
);

  dpath_ctrl_t               dctl;
  dpath_status_t             status;
  logic                      hit;
  logic                      victim_dirty;
  logic [`CACHE_TAG_W-1:0]   victim_tag;
  logic [`CACHE_TAG_W-1:0]   req_tag;
  logic [`CACHE_INDEX_W-1:0] index;

  // --------------------------------------------------
  // Control, datapath, tags
  // --------------------------------------------------

  cache_ctrl ctrl_i (
    .clk, .reset,
    .memreq_val, .memresp_rdy, .cache_req_rdy, .cache_resp_val,
    .hit, .victim_dirty, .status,
    .memreq_rdy, .memresp_val, .cache_req_val, .cache_resp_rdy,
    .dctl
  );

  cache_dpath dpath_i (
    .clk, .reset, .memreq, .dctl, .victim_tag, .cache_resp,
    .index, .req_tag, .status, .cache_req, .memresp
  );

  cache_tag_array tags_i (
    .clk, .reset, .index, .req_tag, .dctl,
    .hit, .victim_dirty, .victim_tag
  );

endmodule

/* tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model
  import cache_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic [1:0] delay,      // Wait cycles for the next accepted request
  input  logic       req_val,
  input  mem_req_t   req,
  output logic       req_rdy,
  output logic       resp_val,
  output mem_resp_t  resp,
  input  logic       resp_rdy
);

  logic [31:0] mem [logic [29:0]];  // Sparse, only written words stored
  logic        busy = 1'b0;
  logic [1:0]  wait_cnt = '0;
  logic [1:0]  dly_s;
  logic        req_fire;
  logic        resp_fire;
  mem_req_t    req_s;                // Payload as seen at the edge
  mem_req_t    cur;

  initial begin
    req_rdy  = 1'b1;
    resp_val = 1'b0;
    resp     = '0;
    cur      = '0;
  end

  // Untouched words follow the initial content rule
  function automatic logic [31:0] read_word(input logic [29:0] waddr);
    if (mem.exists(waddr)) return mem[waddr];
    return {2'b00, waddr} ^ 32'hcafe0000;
  endfunction

  always @(posedge clk) begin
    req_fire  = req_val && req_rdy;   // Sampled before the edge settles
    resp_fire = resp_val && resp_rdy;
    req_s     = req;
    dly_s     = delay;
    #1;
    if (reset) begin
      req_rdy  = 1'b1;
      resp_val = 1'b0;
      busy     = 1'b0;
    end else begin
      if (resp_fire) begin
        resp_val = 1'b0;
        req_rdy  = 1'b1;  // Ready for the next word
      end
      if (req_fire) begin
        cur      = req_s;
        req_rdy  = 1'b0;
        busy     = 1'b1;
        wait_cnt = dly_s;
        if (req_s.op) mem[req_s.addr[31:2]] = req_s.data;
      end else if (busy && !resp_val) begin
        if (wait_cnt == 2'd0) begin
          resp_val  = 1'b1;
          resp.op   = cur.op;
          resp.data = cur.op ? 32'h0 : read_word(cur.addr[31:2]);
          busy      = 1'b0;
        end else begin
          wait_cnt = wait_cnt - 2'd1;
        end
      end
    end
  end

endmodule

/* tb_cache_top.sv */
`timescale 1ns/1ps

module tb_cache_top
  import cache_pkg::*;
();

  localparam int NUM_PAT  = 20;
  localparam int PERIOD   = 40;
  localparam int MAX_CYC  = NUM_PAT * 200;  // Watchdog budget

  logic        clk = 1'b0;
  logic        reset;
  logic        memreq_val;
  mem_req_t    memreq;
  logic        memreq_rdy;
  logic        memresp_val;
  mem_resp_t   memresp;
  logic        memresp_rdy;
  logic        cache_req_val;
  mem_req_t    cache_req;
  logic        cache_req_rdy;
  logic        cache_resp_val;
  mem_resp_t   cache_resp;
  logic        cache_resp_rdy;
  logic [1:0]  mem_delay = '0;
  logic        stall_en = 1'b0;
  logic [31:0] lfsr_q = 32'hef83;
  logic [31:0] pat [NUM_PAT*4];
  int          errors = 0;
  int          checks = 0;

  always #(PERIOD/2) clk = ~clk;

  cache_top cache_top_i (.*);

  tb_mem_model mem_i (
    .clk, .reset, .delay(mem_delay),
    .req_val(cache_req_val), .req(cache_req), .req_rdy(cache_req_rdy),
    .resp_val(cache_resp_val), .resp(cache_resp), .resp_rdy(cache_resp_rdy)
  );

  // --------------------------------------------------
  // Random source, Fibonacci taps 32 22 2 1
  // --------------------------------------------------

  function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  always @(posedge clk) begin
    #1;
    mem_delay[1] = lfsr_bit();
    mem_delay[0] = lfsr_bit();
    memresp_rdy  = stall_en ? lfsr_bit() : 1'b1;  // Random back-pressure
  end

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // --------------------------------------------------
  // One processor transaction
  // --------------------------------------------------

  task automatic run_transaction(input int n);
    logic [31:0] op;
    logic [31:0] held;
    logic        seen;
    logic        is_write;
    int          cycles;
    op       = pat[n*4];
    is_write = (op == 32'd1);  // Codes 0, 2 and 3 are all reads
    seen     = 1'b0;
    @(posedge clk);
    #1;
    stall_en   = (op == 32'd2);
    memreq_val = 1'b1;
    memreq     = {is_write, pat[n*4+1], pat[n*4+2]};
    do @(posedge clk); while (!memreq_rdy);  // Accepted on this edge
    #1;
    memreq_val = 1'b0;
    cycles     = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (memresp_val && seen) check_value(memresp.data, held, "held response data");
      if (memresp_val && !seen) begin
        held = memresp.data;
        seen = 1'b1;
      end
      if (memresp_val && memresp_rdy) break;
    end
    if (!is_write) check_value(memresp.data, pat[n*4+3], $sformatf("read data pattern %0d", n));
    check_value({31'b0, memresp.op}, {31'b0, is_write},
                $sformatf("response type pattern %0d", n));
    if (op == 32'd3) check_value(cycles, 32'd2, $sformatf("hit latency pattern %0d", n));
  endtask

  // --------------------------------------------------
  // Main sequence and watchdog
  // --------------------------------------------------

  initial begin
    reset      = 1'b1;
    memreq_val = 1'b0;
    memreq     = '0;
    memresp_rdy = 1'b1;
    $readmemh("cache_patterns.txt", pat);
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int i = 0; i < NUM_PAT; i++) begin
      run_transaction(i);
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    repeat (MAX_CYC) @(posedge clk);
    $display("Timeout: transactions did not finish within %0d cycles", MAX_CYC);
    $display("Test failures found");
    $finish;
  end

endmodule

/* cache_patterns.txt */
// Columns: op (0 read, 1 write, 2 read with stalls, 3 read with hit timing),
// byte address, write data, expected read data
00000000 00000100 00000000 cafe0040
00000003 00000104 00000000 cafe0041
00000001 00000108 12345678 00000000
00000003 00000108 00000000 12345678
00000000 00000208 00000000 cafe0082
00000000 0000010c 00000000 cafe0043
00000002 00000108 00000000 12345678
00000001 0000020c a5a5a5a5 00000000
00000002 00000100 00000000 cafe0040
00000002 0000020c 00000000 a5a5a5a5
00000002 00001234 00000000 cafe048d
00000001 00001230 deadbeef 00000000
00000000 00002230 00000000 cafe088c
00000002 00001230 00000000 deadbeef
00000003 00001234 00000000 cafe048d
00000000 000000f0 00000000 cafe003c
00000001 000000f4 0badf00d 00000000
00000003 000000f4 00000000 0badf00d
00000000 000010f4 00000000 cafe043d
00000002 000000f4 00000000 0badf00d

/* filelist.f */
+incdir+.
cache_pkg.sv
cache_tag_array.sv
cache_dpath.sv
cache_ctrl.sv
cache_top.sv
tb_mem_model.sv
tb_cache_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f filelist.f --top-module tb_cache_top -o sim_cache
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_cache > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "All tests passed!" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
